// ==== logic/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

    localparam int XLEN = 64;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_32  = 7'b0111011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_AND  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_ADD  = 4'b0011,
        ALU_SUB  = 4'b0100,
        ALU_SRA  = 4'b0101,
        ALU_SLTU = 4'b1001,
        ALU_ADDW = 4'b1011
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE = 2'd0,
        MEM_D    = 2'd1,  // doubleword.
        MEM_W    = 2'd2,  // word, sign-extended.
        MEM_BU   = 2'd3   // byte, zero-extended.
    } mem_size_e;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_SRA  = 3'b101;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_LD   = 3'b011;
    localparam logic [2:0] F3_LBU  = 3'b100;
    localparam logic [2:0] F3_SD   = 3'b011;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // selects SUB and SRA.

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_e    opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_e     opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            opcode_e    opcode;
        } s_fmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            opcode_e    opcode;
        } b_fmt;
    } instr_u;

endpackage

`default_nettype wire

// ==== logic/reg_file.sv ====
`default_nettype none

module reg_file (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [4:0]                   rs1_addr,
    input  logic [4:0]                   rs2_addr,
    output logic [rv_exec_pkg::XLEN-1:0] rs1_data,
    output logic [rv_exec_pkg::XLEN-1:0] rs2_data,
    input  logic                         rf_we,
    input  logic [4:0]                   rf_waddr,
    input  logic [rv_exec_pkg::XLEN-1:0] rf_wdata
);
    import rv_exec_pkg::*;

    logic [XLEN-1:0] regs [32];

    // x0 is hardwired, whatever the array holds.
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we && rf_waddr != 5'd0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`default_nettype none

module alu (
    input  rv_exec_pkg::alu_op_e         alu_op,
    input  logic [rv_exec_pkg::XLEN-1:0] alu_src1,
    input  logic [rv_exec_pkg::XLEN-1:0] alu_src2,
    output logic [rv_exec_pkg::XLEN-1:0] alu_res,
    output logic                         zero
);
    import rv_exec_pkg::*;

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [31:0]     sum_w;
    logic [5:0]      shamt;
    logic            lt_u;

    assign sum   = alu_src1 + alu_src2;
    assign diff  = alu_src1 - alu_src2;
    assign sum_w = sum[31:0];  // the low word of the full add is the ADDW result.
    assign shamt = alu_src2[5:0];
    assign lt_u  = (alu_src1 < alu_src2);

    // branches compare through the subtractor, whatever alu_op says.
    assign zero = (diff == '0);

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                alu_res = sum;
            end
            ALU_ADDW: begin
                alu_res = {{(XLEN-32){sum_w[31]}}, sum_w};
            end
            ALU_SUB: begin
                alu_res = diff;
            end
            ALU_SLTU: begin
                alu_res = {{(XLEN-1){1'b0}}, lt_u};
            end
            ALU_SRA: begin
                alu_res = $signed(alu_src1) >>> shamt;  // fills with the sign bit.
            end
            ALU_AND: begin
                alu_res = alu_src1 & alu_src2;
            end
            ALU_SLL: begin
                alu_res = alu_src1 << shamt;
            end
            default: begin
                alu_res = diff;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instr_valid,
    input  logic [31:0]                  instr,
    output logic [4:0]                   rs1_addr,
    output logic [4:0]                   rs2_addr,
    input  logic [rv_exec_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_exec_pkg::XLEN-1:0] rs2_data,
    input  logic                         rf_we,
    input  logic [4:0]                   rf_waddr,
    input  logic [rv_exec_pkg::XLEN-1:0] rf_wdata,
    output logic                         ex_valid,
    output logic [4:0]                   ex_rd,
    output rv_exec_pkg::alu_op_e         ex_alu_op,
    output logic [rv_exec_pkg::XLEN-1:0] ex_src1,
    output logic [rv_exec_pkg::XLEN-1:0] ex_src2,
    output rv_exec_pkg::mem_size_e       ex_mem_size,
    output logic                         ex_store,
    output logic [rv_exec_pkg::XLEN-1:0] ex_store_data,
    output logic                         ex_branch,
    output logic                         ex_branch_ne
);
    import rv_exec_pkg::*;

    instr_u          iw;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] dec_src2;
    logic            dec_valid;
    alu_op_e         dec_op;
    mem_size_e       dec_size;
    logic            dec_store;
    logic            dec_branch;
    logic            dec_ne;

    assign iw       = instr;
    assign rs1_addr = iw.r_fmt.rs1;
    assign rs2_addr = iw.r_fmt.rs2;
    assign imm_i    = {{(XLEN-12){iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
    assign imm_s    = {{(XLEN-12){iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};

    // the instruction in execute writes back at the same edge, so its result wins.
    assign op1 = (rf_we && rf_waddr == rs1_addr && rs1_addr != 5'd0) ? rf_wdata : rs1_data;
    assign op2 = (rf_we && rf_waddr == rs2_addr && rs2_addr != 5'd0) ? rf_wdata : rs2_data;

    always_comb begin
        dec_valid  = 1'b0;
        dec_op     = ALU_ADD;  // address generation for loads and stores.
        dec_src2   = op2;
        dec_size   = MEM_NONE;
        dec_store  = 1'b0;
        dec_branch = 1'b0;
        dec_ne     = 1'b0;
        case (iw.r_fmt.opcode)
            OP: begin
                dec_valid = 1'b1;
                case ({iw.r_fmt.funct7, iw.r_fmt.funct3})
                    {F7_BASE, F3_ADD}:  dec_op = ALU_ADD;
                    {F7_ALT, F3_ADD}:   dec_op = ALU_SUB;
                    {F7_BASE, F3_SLL}:  dec_op = ALU_SLL;
                    {F7_BASE, F3_SLTU}: dec_op = ALU_SLTU;
                    {F7_ALT, F3_SRA}:   dec_op = ALU_SRA;
                    {F7_BASE, F3_AND}:  dec_op = ALU_AND;
                    default:            dec_valid = 1'b0;
                endcase
            end
            OP_32: begin
                dec_op    = ALU_ADDW;
                dec_valid = (iw.r_fmt.funct7 == F7_BASE) && (iw.r_fmt.funct3 == F3_ADD);
            end
            OP_IMM: begin
                dec_src2  = imm_i;
                dec_valid = (iw.i_fmt.funct3 == F3_ADD);
            end
            LOAD: begin
                dec_src2  = imm_i;
                dec_valid = 1'b1;
                case (iw.i_fmt.funct3)
                    F3_LD:   dec_size = MEM_D;
                    F3_LW:   dec_size = MEM_W;
                    F3_LBU:  dec_size = MEM_BU;
                    default: dec_valid = 1'b0;
                endcase
            end
            STORE: begin
                dec_src2  = imm_s;
                dec_size  = MEM_D;
                dec_store = 1'b1;
                dec_valid = (iw.s_fmt.funct3 == F3_SD);
            end
            BRANCH: begin
                dec_op     = ALU_SUB;
                dec_branch = 1'b1;
                dec_ne     = (iw.b_fmt.funct3 == F3_BNE);
                dec_valid  = (iw.b_fmt.funct3 == F3_BEQ) || (iw.b_fmt.funct3 == F3_BNE);
            end
            default: begin
                dec_valid = 1'b0;  // anything else passes as a bubble.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= instr_valid && dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_rd         <= iw.r_fmt.rd;
        ex_alu_op     <= dec_op;
        ex_src1       <= op1;
        ex_src2       <= dec_src2;
        ex_mem_size   <= dec_size;
        ex_store      <= dec_store;
        ex_store_data <= op2;
        ex_branch     <= dec_branch;
        ex_branch_ne  <= dec_ne;
    end

endmodule

`default_nettype wire

// ==== logic/mem_writeback.sv ====
`default_nettype none

module mem_writeback #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ex_valid,
    input  logic [4:0]                   ex_rd,
    input  rv_exec_pkg::mem_size_e       ex_mem_size,
    input  logic                         ex_store,
    input  logic [rv_exec_pkg::XLEN-1:0] ex_store_data,
    input  logic                         ex_branch,
    input  logic                         ex_branch_ne,
    input  logic [rv_exec_pkg::XLEN-1:0] alu_res,
    input  logic                         zero,
    output logic                         rf_we,
    output logic [4:0]                   rf_waddr,
    output logic [rv_exec_pkg::XLEN-1:0] rf_wdata,
    output logic                         wb_valid,
    output logic [4:0]                   wb_rd,
    output logic [rv_exec_pkg::XLEN-1:0] wb_data,
    output logic                         branch_valid,
    output logic                         branch_taken
);
    import rv_exec_pkg::*;

    localparam int IDX_W = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0]       dmem [DMEM_DEPTH];
    logic [DMEM_DEPTH-1:0] dmem_vld;
    logic [IDX_W-1:0]      idx;
    logic [XLEN-1:0]       rd_word;
    logic [31:0]           rd_half;
    logic [7:0]            rd_byte;
    logic                  do_store;
    logic                  taken;

    assign idx      = alu_res[IDX_W+2:3];  // doubleword index, wraps at the depth.
    assign do_store = ex_valid && ex_store;

    // an entry never stored since reset reads as zero.
    assign rd_word = dmem_vld[idx] ? dmem[idx] : '0;
    assign rd_half = alu_res[2] ? rd_word[63:32] : rd_word[31:0];
    assign rd_byte = rd_word[{alu_res[2:0], 3'b000} +: 8];

    always_comb begin
        case (ex_mem_size)
            MEM_D:   rf_wdata = rd_word;
            MEM_W:   rf_wdata = {{(XLEN-32){rd_half[31]}}, rd_half};
            MEM_BU:  rf_wdata = {{(XLEN-8){1'b0}}, rd_byte};
            default: rf_wdata = alu_res;
        endcase
    end

    assign rf_we    = ex_valid && !ex_store && !ex_branch && (ex_rd != 5'd0);
    assign rf_waddr = ex_rd;
    assign taken    = ex_branch_ne ? !zero : zero;

    always_ff @(posedge clk) begin
        if (do_store) begin
            dmem[idx] <= ex_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dmem_vld <= '0;
        end else if (do_store) begin
            dmem_vld[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid     <= 1'b0;
            branch_valid <= 1'b0;
        end else begin
            wb_valid     <= rf_we;  // x0 writes stay silent.
            branch_valid <= ex_valid && ex_branch;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd        <= rf_waddr;
        wb_data      <= rf_wdata;
        branch_taken <= taken;
    end

endmodule

`default_nettype wire

// ==== logic/exec_core.sv ====
`default_nettype none

module exec_core #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instr_valid,
    input  logic [31:0]                  instr,
    output logic                         wb_valid,
    output logic [4:0]                   wb_rd,
    output logic [rv_exec_pkg::XLEN-1:0] wb_data,
    output logic                         branch_valid,
    output logic                         branch_taken
);
    import rv_exec_pkg::*;

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [XLEN-1:0] rf_wdata;
    logic            ex_valid;
    logic [4:0]      ex_rd;
    alu_op_e         ex_alu_op;
    logic [XLEN-1:0] ex_src1;
    logic [XLEN-1:0] ex_src2;
    mem_size_e       ex_mem_size;
    logic            ex_store;
    logic [XLEN-1:0] ex_store_data;
    logic            ex_branch;
    logic            ex_branch_ne;
    logic [XLEN-1:0] alu_res;
    logic            zero;

    instr_decoder u_decoder (
        .clk, .rst, .instr_valid, .instr,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .rf_we, .rf_waddr, .rf_wdata,
        .ex_valid, .ex_rd, .ex_alu_op, .ex_src1, .ex_src2,
        .ex_mem_size, .ex_store, .ex_store_data, .ex_branch, .ex_branch_ne
    );

    // operands come from here and from the forwarding path in the decoder.
    reg_file u_reg_file (
        .clk, .rst,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .rf_we, .rf_waddr, .rf_wdata
    );

    alu u_alu (
        .alu_op   (ex_alu_op),
        .alu_src1 (ex_src1),
        .alu_src2 (ex_src2),
        .alu_res  (alu_res),
        .zero     (zero)
    );

    mem_writeback #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_mem_writeback (
        .clk, .rst,
        .ex_valid, .ex_rd, .ex_mem_size, .ex_store, .ex_store_data,
        .ex_branch, .ex_branch_ne, .alu_res, .zero,
        .rf_we, .rf_waddr, .rf_wdata,
        .wb_valid, .wb_rd, .wb_data, .branch_valid, .branch_taken
    );

endmodule

`default_nettype wire

// ==== include/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// stops the run on the first failure.
task automatic report_fail(input string test_name, input string msg);
    $display("ERROR: %s: %s", test_name, msg);
    $display("CHECKS FAILED");
    $fatal(1, "%s: %s", test_name, msg);
endtask

task automatic compare_data(
    input string       test_name,
    input logic [63:0] expected,
    input logic [63:0] actual
);
    if (actual !== expected) begin
        $display("ERROR: %s: data expected %h, actual %h", test_name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "%s: data mismatch", test_name);
    end
endtask

task automatic compare_rd(
    input string      test_name,
    input logic [4:0] expected,
    input logic [4:0] actual
);
    if (actual !== expected) begin
        $display("ERROR: %s: rd expected x%0d, actual x%0d", test_name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "%s: rd mismatch", test_name);
    end
endtask

task automatic compare_flag(
    input string test_name,
    input logic  expected,
    input logic  actual
);
    if (actual !== expected) begin
        $display("ERROR: %s: flag expected %b, actual %b", test_name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "%s: flag mismatch", test_name);
    end
endtask

`endif

// ==== tests/tb_exec_core.sv ====
`default_nettype none

module tb_exec_core;
    import rv_exec_pkg::*;

    localparam int RANDOM_COUNT = 200;
    // issue slots of the directed tests, plus up to two bubbles per random instruction.
    localparam int TOTAL_SLOTS = 8 + 40 + 70 + 20 + 70 + 20 + RANDOM_COUNT * 3;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [63:0] wb_data;
    logic        branch_valid;
    logic        branch_taken;

    string       test_name;
    logic [63:0] mregs [32];
    logic [63:0] mmem [256];
    logic        exp_wb [2];  // index 0 is the newest instruction.
    logic [4:0]  exp_rd [2];
    logic [63:0] exp_data [2];
    logic        exp_br [2];
    logic        exp_taken [2];

    exec_core #(
        .DMEM_DEPTH (256)
    ) u_dut (
        .clk, .rst, .instr_valid, .instr,
        .wb_valid, .wb_rd, .wb_data, .branch_valid, .branch_taken
    );

    `include "tb_checks.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #((TOTAL_SLOTS + 50) * 40);
        report_fail("watchdog", "the tests did not finish before the timeout");
    end

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input opcode_e op);
        instr_u w;
        w.r_fmt.funct7 = f7;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.funct3 = f3;
        w.r_fmt.rd     = rd;
        w.r_fmt.opcode = op;
        return w;
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input opcode_e op);
        instr_u w;
        w.i_fmt.imm    = imm;
        w.i_fmt.rs1    = rs1;
        w.i_fmt.funct3 = f3;
        w.i_fmt.rd     = rd;
        w.i_fmt.opcode = op;
        return w;
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        instr_u w;
        w.s_fmt.imm_hi = imm[11:5];
        w.s_fmt.rs2    = rs2;
        w.s_fmt.rs1    = rs1;
        w.s_fmt.funct3 = F3_SD;
        w.s_fmt.imm_lo = imm[4:0];
        w.s_fmt.opcode = STORE;
        return w;
    endfunction

    function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        instr_u w;
        w.b_fmt.imm12   = 1'b0;
        w.b_fmt.imm10_5 = 6'd0;
        w.b_fmt.rs2     = rs2;
        w.b_fmt.rs1     = rs1;
        w.b_fmt.funct3  = f3;
        w.b_fmt.imm4_1  = 4'b1000;  // the offset of 16 is unused without a PC.
        w.b_fmt.imm11   = 1'b0;
        w.b_fmt.opcode  = BRANCH;
        return w;
    endfunction

    // the reference model is updated in program order as each instruction is issued.
    task automatic predict(input logic valid, input logic [31:0] word);
        instr_u      w;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] addr;
        logic [63:0] dw;
        logic [63:0] res;
        logic        wr;
        w = word;
        a = mregs[w.r_fmt.rs1];
        b = mregs[w.r_fmt.rs2];
        addr = a + {{52{w.i_fmt.imm[11]}}, w.i_fmt.imm};
        dw = mmem[addr[10:3]];
        res = 64'd0;
        wr = 1'b0;
        exp_wb[0] = 1'b0;
        exp_rd[0] = w.r_fmt.rd;
        exp_data[0] = 64'd0;
        exp_br[0] = 1'b0;
        exp_taken[0] = 1'b0;
        if (valid) begin
            case (w.r_fmt.opcode)
                OP: begin
                    wr = 1'b1;
                    case ({w.r_fmt.funct7, w.r_fmt.funct3})
                        {F7_BASE, F3_ADD}:  res = a + b;
                        {F7_ALT, F3_ADD}:   res = a - b;
                        {F7_BASE, F3_SLL}:  res = a << b[5:0];
                        {F7_BASE, F3_SLTU}: res = (a < b) ? 64'd1 : 64'd0;
                        {F7_ALT, F3_SRA}:   res = $signed(a) >>> b[5:0];
                        {F7_BASE, F3_AND}:  res = a & b;
                        default:            wr = 1'b0;
                    endcase
                end
                OP_32: begin
                    res = {32'd0, a[31:0] + b[31:0]};
                    res[63:32] = {32{res[31]}};  // the sum is sign-extended from bit 31.
                    wr = (w.r_fmt.funct7 == F7_BASE) && (w.r_fmt.funct3 == F3_ADD);
                end
                OP_IMM: begin
                    res = addr;
                    wr = (w.i_fmt.funct3 == F3_ADD);
                end
                LOAD: begin
                    wr = 1'b1;
                    case (w.i_fmt.funct3)
                        F3_LD:   res = dw;
                        F3_LW: begin
                            res = addr[2] ? {{32{dw[63]}}, dw[63:32]} : {{32{dw[31]}}, dw[31:0]};
                        end
                        F3_LBU:  res = {56'd0, dw[addr[2:0] * 8 +: 8]};
                        default: wr = 1'b0;
                    endcase
                end
                STORE: begin
                    addr = a + {{52{w.s_fmt.imm_hi[6]}}, w.s_fmt.imm_hi, w.s_fmt.imm_lo};
                    if (w.s_fmt.funct3 == F3_SD) begin
                        mmem[addr[10:3]] = b;
                    end
                end
                BRANCH: begin
                    exp_br[0] = (w.b_fmt.funct3 == F3_BEQ) || (w.b_fmt.funct3 == F3_BNE);
                    exp_taken[0] = (w.b_fmt.funct3 == F3_BNE) ? (a != b) : (a == b);
                end
                default: begin
                    wr = 1'b0;
                end
            endcase
        end
        if (wr && w.r_fmt.rd != 5'd0) begin
            mregs[w.r_fmt.rd] = res;
            exp_wb[0] = 1'b1;
            exp_data[0] = res;
        end
    endtask

    task automatic check_pulses();
        if (wb_valid !== exp_wb[1]) begin
            report_fail(test_name,
                        exp_wb[1] ? "writeback pulse missing" : "unexpected writeback pulse");
        end
        if (exp_wb[1]) begin
            compare_rd(test_name, exp_rd[1], wb_rd);
            compare_data(test_name, exp_data[1], wb_data);
        end
        if (branch_valid !== exp_br[1]) begin
            report_fail(test_name, exp_br[1] ? "branch pulse missing" : "unexpected branch pulse");
        end
        if (exp_br[1]) begin
            compare_flag(test_name, exp_taken[1], branch_taken);
        end
    endtask

    // runs on a falling edge and checks the instruction issued two edges back.
    task automatic issue(input logic [31:0] word, input logic valid = 1'b1);
        check_pulses();
        exp_wb[1] = exp_wb[0];
        exp_rd[1] = exp_rd[0];
        exp_data[1] = exp_data[0];
        exp_br[1] = exp_br[0];
        exp_taken[1] = exp_taken[0];
        predict(valid, word);
        instr_valid = valid;
        instr = word;
        @(negedge clk);
    endtask

    task automatic drain();
        repeat (2) issue(32'd0, 1'b0);
    endtask

    // builds a 64-bit constant from 11-bit chunks, with x31 holding the shift amount.
    task automatic load_const(input logic [4:0] rd, input logic [63:0] value);
        int i;
        issue(i_word(12'd11, 5'd0, F3_ADD, 5'd31, OP_IMM));
        issue(i_word({3'b000, value[63:55]}, 5'd0, F3_ADD, rd, OP_IMM));
        for (i = 4; i >= 0; i--) begin
            issue(r_word(F7_BASE, F3_SLL, rd, rd, 5'd31, OP));
            issue(i_word({1'b0, 11'(value >> (11 * i))}, rd, F3_ADD, rd, OP_IMM));
        end
    endtask

    function automatic logic [31:0] random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] word;
        rd = 5'($urandom);
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        imm = 12'($urandom);
        case ($urandom_range(13, 0))
            0:       word = r_word(F7_BASE, F3_ADD, rd, rs1, rs2, OP);
            1:       word = r_word(F7_BASE, F3_ADD, rd, rs1, rs2, OP_32);
            2:       word = r_word(F7_ALT, F3_ADD, rd, rs1, rs2, OP);
            3:       word = r_word(F7_BASE, F3_SLTU, rd, rs1, rs2, OP);
            4:       word = r_word(F7_ALT, F3_SRA, rd, rs1, rs2, OP);
            5:       word = r_word(F7_BASE, F3_AND, rd, rs1, rs2, OP);
            6:       word = r_word(F7_BASE, F3_SLL, rd, rs1, rs2, OP);
            7:       word = i_word(imm, rs1, F3_ADD, rd, OP_IMM);
            8:       word = i_word(imm, rs1, F3_LD, rd, LOAD);
            9:       word = i_word(imm, rs1, F3_LW, rd, LOAD);
            10:      word = i_word(imm, rs1, F3_LBU, rd, LOAD);
            11:      word = s_word(imm, rs2, rs1);
            12:      word = b_word(F3_BEQ, rs1, rs2);
            default: word = b_word(F3_BNE, rs1, rs2);
        endcase
        return word;
    endfunction

    task automatic test_reset();
        int i;
        test_name = "test_reset";
        repeat (8) begin
            @(negedge clk);
            if (wb_valid !== 1'b0 || branch_valid !== 1'b0) begin
                report_fail(test_name, "a result pulse was high during reset");
            end
        end
        rst = 1'b0;
        for (i = 0; i < 32; i++) begin
            issue(r_word(F7_BASE, F3_ADD, 5'd31, 5'(i), 5'd0, OP));
        end
        drain();
    endtask

    task automatic test_alu_ops();
        test_name = "test_alu_ops";
        load_const(5'd1, 64'hfedc_ba98_7654_3210);
        load_const(5'd2, 64'h0000_0000_7fff_ffff);
        issue(i_word(12'd1, 5'd0, F3_ADD, 5'd3, OP_IMM));
        issue(i_word(12'hff9, 5'd0, F3_ADD, 5'd4, OP_IMM));
        issue(i_word(12'h7ff, 5'd0, F3_ADD, 5'd5, OP_IMM));
        issue(i_word(12'd63, 5'd0, F3_ADD, 5'd6, OP_IMM));
        issue(r_word(F7_BASE, F3_ADD, 5'd7, 5'd1, 5'd2, OP));
        issue(r_word(F7_BASE, F3_ADD, 5'd8, 5'd2, 5'd3, OP_32));
        issue(r_word(F7_ALT, F3_ADD, 5'd9, 5'd3, 5'd1, OP));
        issue(r_word(F7_BASE, F3_SLTU, 5'd10, 5'd1, 5'd4, OP));
        issue(r_word(F7_BASE, F3_SLTU, 5'd11, 5'd4, 5'd1, OP));
        issue(r_word(F7_ALT, F3_SRA, 5'd12, 5'd1, 5'd5, OP));
        issue(r_word(F7_ALT, F3_SRA, 5'd13, 5'd1, 5'd3, OP));
        issue(r_word(F7_BASE, F3_AND, 5'd14, 5'd1, 5'd2, OP));
        issue(r_word(F7_BASE, F3_SLL, 5'd15, 5'd1, 5'd6, OP));
        issue(r_word(F7_BASE, F3_SLL, 5'd16, 5'd4, 5'd5, OP));
        drain();
    endtask

    task automatic test_forwarding();
        test_name = "test_forwarding";
        issue(i_word(12'd100, 5'd0, F3_ADD, 5'd5, OP_IMM));
        issue(r_word(F7_BASE, F3_ADD, 5'd6, 5'd5, 5'd5, OP));
        issue(r_word(F7_ALT, F3_ADD, 5'd7, 5'd6, 5'd5, OP));
        issue(r_word(F7_BASE, F3_SLL, 5'd8, 5'd7, 5'd3, OP));
        issue(r_word(F7_BASE, F3_AND, 5'd9, 5'd8, 5'd6, OP));
        issue(i_word(12'd5, 5'd0, F3_ADD, 5'd0, OP_IMM));
        issue(r_word(F7_BASE, F3_ADD, 5'd10, 5'd0, 5'd0, OP));
        issue(32'h0000_006f);  // a jump opcode, which this core ignores.
        issue(r_word(F7_BASE, F3_ADD, 5'd11, 5'd9, 5'd10, OP));
        drain();
    endtask

    task automatic test_loads_stores();
        int i;
        test_name = "test_loads_stores";
        load_const(5'd10, 64'h8123_4567_89ab_cdef);
        load_const(5'd11, 64'h7f00_11ff_0123_80fe);
        issue(i_word(12'h100, 5'd0, F3_ADD, 5'd20, OP_IMM));
        issue(s_word(12'd0, 5'd10, 5'd20));
        issue(s_word(12'd8, 5'd11, 5'd20));
        issue(i_word(12'd0, 5'd20, F3_LD, 5'd12, LOAD));
        issue(i_word(12'd8, 5'd20, F3_LD, 5'd13, LOAD));
        issue(i_word(12'd0, 5'd20, F3_LW, 5'd14, LOAD));
        issue(i_word(12'd4, 5'd20, F3_LW, 5'd15, LOAD));
        issue(i_word(12'd8, 5'd20, F3_LW, 5'd16, LOAD));
        issue(i_word(12'd12, 5'd20, F3_LW, 5'd17, LOAD));
        for (i = 0; i < 16; i++) begin
            issue(i_word(12'(i), 5'd20, F3_LBU, 5'd18, LOAD));
        end
        issue(r_word(F7_BASE, F3_ADD, 5'd19, 5'd12, 5'd18, OP));
        issue(s_word(12'hff8, 5'd19, 5'd20));
        issue(i_word(12'hff8, 5'd20, F3_LD, 5'd21, LOAD));
        drain();
    endtask

    task automatic test_branches();
        test_name = "test_branches";
        issue(i_word(12'd5, 5'd0, F3_ADD, 5'd1, OP_IMM));
        issue(i_word(12'd5, 5'd0, F3_ADD, 5'd2, OP_IMM));
        issue(i_word(12'd7, 5'd0, F3_ADD, 5'd3, OP_IMM));
        issue(b_word(F3_BEQ, 5'd1, 5'd2));
        issue(b_word(F3_BEQ, 5'd1, 5'd3));
        issue(b_word(F3_BNE, 5'd1, 5'd2));
        issue(b_word(F3_BNE, 5'd1, 5'd3));
        issue(32'd0, 1'b0);
        issue(i_word(12'd7, 5'd0, F3_ADD, 5'd4, OP_IMM));
        issue(b_word(F3_BEQ, 5'd4, 5'd3));
        issue(b_word(F3_BNE, 5'd4, 5'd3));
        drain();
    endtask

    task automatic test_random_mix();
        int n;
        test_name = "test_random_mix";
        for (n = 0; n < RANDOM_COUNT; n++) begin
            issue(random_instr());
            repeat ($urandom_range(2, 0)) issue($urandom, 1'b0);
        end
        drain();
    endtask

    initial begin
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = 32'd0;
        void'($urandom(32'h2bc8_074c));
        for (int i = 0; i < 32; i++) begin
            mregs[i] = 64'd0;
        end
        for (int i = 0; i < 256; i++) begin
            mmem[i] = 64'd0;
        end
        for (int i = 0; i < 2; i++) begin
            exp_wb[i] = 1'b0;
            exp_rd[i] = 5'd0;
            exp_data[i] = 64'd0;
            exp_br[i] = 1'b0;
            exp_taken[i] = 1'b0;
        end
        test_reset();
        test_alu_ops();
        test_forwarding();
        test_loads_stores();
        test_branches();
        test_random_mix();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
logic/rv_exec_pkg.sv
logic/reg_file.sv
logic/alu.sv
logic/instr_decoder.sv
logic/mem_writeback.sv
logic/exec_core.sv
tests/tb_exec_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -Wno-fatal \
    --top-module tb_exec_core \
    -f verilog.f \
    -o tb_exec_core

./obj_dir/tb_exec_core
